// File: src/cpuPkg.sv
package cpuPkg;

	// Datapath geometry, fixed by the encoding
	localparam int wordW = 16;        // Data, address and instruction width
	localparam int regCount = 4;      // Architectural registers
	localparam int regIdxW = 2;       // Bits to select one register
	localparam int addrFieldW = 11;   // Address field in bits 11:1

	// Opcodes live in bits 15:14
	localparam logic [1:0] opAdd = 2'b00;
	localparam logic [1:0] opLd = 2'b01;
	localparam logic [1:0] opSt = 2'b10;
	localparam logic [1:0] opBrz = 2'b11;

	// Next PC select codes
	localparam logic [1:0] pcSelInc = 2'b00;  // PC plus one
	localparam logic [1:0] pcSelRel = 2'b01;  // PC plus sign-extended offset
	localparam logic [1:0] pcSelReg = 2'b10;  // Jump to register value

	// Every instruction word parses both ways
	// Register fields are pulled out even when the opcode ignores them
	// Mode bit set means register addressing
	typedef union packed {
		struct packed {
			logic [1:0] opcode;
			logic [regIdxW-1:0] rd;       // Write target, or store source for ST absolute
			logic [regIdxW-1:0] rs1;      // Adder input A, address or branch target
			logic [regIdxW-1:0] rs2;      // Adder input B, store data
			logic [6:0] unused;
			logic mode;
		} regForm;
		struct packed {
			logic [1:0] opcode;
			logic [regIdxW-1:0] rd;
			logic [addrFieldW-1:0] addr;  // Absolute address or branch offset
			logic mode;
		} addrForm;
	} instrWord;

	// regForm bits
	//   15:14 opcode
	//   13:12 rd
	//   11:10 rs1
	//   9:8   rs2
	//   7:1   don't care
	//   0     mode
	//
	// addrForm bits
	//   15:14 opcode
	//   13:12 rd
	//   11:1  address field
	//   0     mode

endpackage

// File: src/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input cpuPkg::instrWord instr,
	input logic zFlag,                                  // Zero flag from last ADD
	input logic rstN,
	output logic [1:0] nextPcSel,                       // Next PC source
	output logic [cpuPkg::regIdxW-1:0] rdSel,           // Write back index
	output logic [cpuPkg::regIdxW-1:0] rs1Sel,
	output logic [cpuPkg::regIdxW-1:0] rs2Sel,
	output logic regWrEn,
	output logic wbFromMem,                             // Write back from data memory
	output logic aluAdd,
	output logic dAddrFromReg,                          // Data address from rs1
	output logic dWe,
	output logic [cpuPkg::wordW-1:0] immAddr            // Extended address field
);

	logic writeReq;   // Register write before reset gating
	logic storeReq;   // Memory write before reset gating

	// Register fields are always extracted
	assign rdSel = instr.regForm.rd;
	assign rs1Sel = instr.regForm.rs1;

	// Nothing gets written while reset is low
	assign regWrEn = rstN & writeReq;
	assign dWe = rstN & storeReq;

	always_comb begin
		// Defaults describe a no-op that just steps the PC
		nextPcSel = cpuPkg::pcSelInc;
		rs2Sel = instr.regForm.rs2;
		writeReq = 1'b0;
		wbFromMem = 1'b0;
		aluAdd = 1'b0;
		dAddrFromReg = 1'b0;
		storeReq = 1'b0;
		immAddr = '0;

		case (instr.regForm.opcode)
			cpuPkg::opAdd: begin
				aluAdd = 1'b1;      // Sum and flag update
				writeReq = 1'b1;    // rd gets the sum
			end

			cpuPkg::opLd: begin
				wbFromMem = 1'b1;   // rd gets memory data
				writeReq = 1'b1;
				if (instr.addrForm.mode) begin
					dAddrFromReg = 1'b1;  // Address held in rs1
				end else begin
					// Zero fill the 11-bit field
					immAddr = {{(cpuPkg::wordW - cpuPkg::addrFieldW){1'b0}},
						instr.addrForm.addr};
				end
			end

			cpuPkg::opSt: begin
				storeReq = 1'b1;
				if (instr.addrForm.mode) begin
					dAddrFromReg = 1'b1;  // Address in rs1, data in rs2
				end else begin
					// Field bits overlap rs2, so data comes from rd
					rs2Sel = instr.addrForm.rd;
					immAddr = {{(cpuPkg::wordW - cpuPkg::addrFieldW){1'b0}},
						instr.addrForm.addr};
				end
			end

			cpuPkg::opBrz: begin
				if (!instr.addrForm.mode) begin
					// Signed offset relative to this PC
					immAddr = {{(cpuPkg::wordW - cpuPkg::addrFieldW)
						{instr.addrForm.addr[cpuPkg::addrFieldW-1]}},
						instr.addrForm.addr};
				end

				// Not taken unless the flag is set
				if (zFlag) begin
					if (instr.addrForm.mode) begin
						nextPcSel = cpuPkg::pcSelReg;  // Target in rs1
					end else begin
						nextPcSel = cpuPkg::pcSelRel;
					end
				end
			end

			default: begin
				nextPcSel = cpuPkg::pcSelInc;
			end
		endcase
	end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic wrEn,
	input logic [cpuPkg::regIdxW-1:0] wrSel,
	input logic [cpuPkg::wordW-1:0] wrData,
	input logic [cpuPkg::regIdxW-1:0] rdSel1,
	input logic [cpuPkg::regIdxW-1:0] rdSel2,
	output logic [cpuPkg::wordW-1:0] rdData1,   // Read port 1, combinational
	output logic [cpuPkg::wordW-1:0] rdData2    // Read port 2, combinational
);

	// Four general registers
	logic [cpuPkg::wordW-1:0] regs [cpuPkg::regCount];

	// Single write port, takes effect at the edge
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrSel] <= wrData;
		end
	end

	// No bypass
	// A read of the register being written still sees the old value
	assign rdData1 = regs[rdSel1];
	assign rdData2 = regs[rdSel2];

	// Port 1 feeds the address, branch target and adder A
	// Port 2 feeds adder B and the store data

endmodule

// File: src/pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
	input logic clk,
	input logic rstN,
	input logic [1:0] nextPcSel,                  // From decoder
	input logic [cpuPkg::wordW-1:0] immAddr,      // Sign-extended branch offset
	input logic [cpuPkg::wordW-1:0] regTarget,    // rs1 value for register branch
	output logic [cpuPkg::wordW-1:0] pc
);

	logic [cpuPkg::wordW-1:0] pcNext;
	logic [cpuPkg::wordW-1:0] pcInc;

	assign pcInc = pc + 1'b1;   // Wraps at the top of memory

	always_comb begin
		case (nextPcSel)
			cpuPkg::pcSelInc: begin
				pcNext = pcInc;
			end
			cpuPkg::pcSelRel: begin
				pcNext = pc + immAddr;  // Offset is relative to this instruction
			end
			default: begin
				// Register target, upper bit alone picks it
				pcNext = regTarget;
			end
		endcase
	end

	// Fetch starts at word 0 after reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

// File: src/execUnit.sv
`timescale 1ns/1ps

module execUnit (
	input logic clk,
	input logic rstN,
	input logic aluAdd,                           // ADD in flight, update flag
	input logic wbFromMem,
	input logic dAddrFromReg,
	input logic [cpuPkg::wordW-1:0] opA,          // rs1 value
	input logic [cpuPkg::wordW-1:0] opB,          // rs2 value
	input logic [cpuPkg::wordW-1:0] immAddr,      // Zero-extended absolute address
	input logic [cpuPkg::wordW-1:0] dRData,       // Data memory read port
	output logic [cpuPkg::wordW-1:0] wbData,
	output logic [cpuPkg::wordW-1:0] dAddr,
	output logic zFlag
);

	logic [cpuPkg::wordW-1:0] sum;
	logic sumZero;

	// Adder, carry out discarded
	assign sum = opA + opB;
	assign sumZero = (sum == '0);

	// Flag only follows ADD
	// Loads, stores and branches leave it alone
	always_ff @(posedge clk) begin
		if (!rstN) begin
			zFlag <= 1'b0;
		end else if (aluAdd) begin
			zFlag <= sumZero;
		end
	end

	// Data address
	// Register form uses rs1, absolute form the instruction field
	assign dAddr = dAddrFromReg ? opA : immAddr;

	// Write back source
	assign wbData = wbFromMem ? dRData : sum;   // LD takes memory, ADD takes sum

endmodule

// File: src/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::wordW-1:0] instr,      // Instruction memory read data
	input logic [cpuPkg::wordW-1:0] dRData,     // Data memory read data
	output logic [cpuPkg::wordW-1:0] pc,        // Instruction memory address
	output logic [cpuPkg::wordW-1:0] dAddr,
	output logic [cpuPkg::wordW-1:0] dWData,
	output logic dWe                            // Data memory write strobe
);

	// Decoder controls
	logic [1:0] nextPcSel;
	logic [cpuPkg::regIdxW-1:0] rdSel;
	logic [cpuPkg::regIdxW-1:0] rs1Sel;
	logic [cpuPkg::regIdxW-1:0] rs2Sel;
	logic regWrEn;
	logic wbFromMem;
	logic aluAdd;
	logic dAddrFromReg;
	logic [cpuPkg::wordW-1:0] immAddr;   // Shared by exec and PC

	// Register read data
	logic [cpuPkg::wordW-1:0] rdData1;
	logic [cpuPkg::wordW-1:0] rdData2;

	// Exec results
	logic [cpuPkg::wordW-1:0] wbData;
	logic zFlag;                         // Loops back into decode

	// Decode, purely combinational
	instrDecoder decoder0 (
		.instr(cpuPkg::instrWord'(instr)),
		.zFlag(zFlag),
		.rstN(rstN),
		.nextPcSel(nextPcSel),
		.rdSel(rdSel),
		.rs1Sel(rs1Sel),
		.rs2Sel(rs2Sel),
		.regWrEn(regWrEn),
		.wbFromMem(wbFromMem),
		.aluAdd(aluAdd),
		.dAddrFromReg(dAddrFromReg),
		.dWe(dWe),
		.immAddr(immAddr)
	);

	// Registers, written at the end of the cycle
	regFile regs0 (
		.clk(clk),
		.rstN(rstN),
		.wrEn(regWrEn),
		.wrSel(rdSel),
		.wrData(wbData),
		.rdSel1(rs1Sel),
		.rdSel2(rs2Sel),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	// Program counter
	pcUnit pc0 (
		.clk(clk),
		.rstN(rstN),
		.nextPcSel(nextPcSel),
		.immAddr(immAddr),
		.regTarget(rdData1),    // BRZ register target in rs1
		.pc(pc)
	);

	// Adder, flag and memory addressing
	execUnit exec0 (
		.clk(clk),
		.rstN(rstN),
		.aluAdd(aluAdd),
		.wbFromMem(wbFromMem),
		.dAddrFromReg(dAddrFromReg),
		.opA(rdData1),
		.opB(rdData2),
		.immAddr(immAddr),
		.dRData(dRData),
		.wbData(wbData),
		.dAddr(dAddr),
		.zFlag(zFlag)
	);

	// Store data straight from read port 2
	assign dWData = rdData2;

endmodule

// File: verification/cpuCoreAsserts.sv
`timescale 1ns/1ps

module cpuCoreAsserts (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::wordW-1:0] instr,
	input logic [cpuPkg::wordW-1:0] pc,
	input logic [cpuPkg::wordW-1:0] dAddr,
	input logic dWe
);

	cpuPkg::instrWord iw;
	logic isLd;
	logic isSt;
	logic isBrz;
	logic [cpuPkg::wordW-1:0] absAddr;   // Zero-extended address field
	int assertFails = 0;                 // Read by the testbench at the end

	assign iw = instr;
	assign isLd = (iw.regForm.opcode == cpuPkg::opLd);
	assign isSt = (iw.regForm.opcode == cpuPkg::opSt);
	assign isBrz = (iw.regForm.opcode == cpuPkg::opBrz);
	assign absAddr = {{(cpuPkg::wordW - cpuPkg::addrFieldW){1'b0}}, iw.addrForm.addr};

	// Memory stays untouched while in reset
	noStoreInReset: assert property (@(posedge clk) !rstN |-> !dWe)
		else begin
			assertFails++;
			$error("dWe high while rstN is low");
		end

	// Straight-line flow for everything but BRZ
	pcStep: assert property (@(posedge clk) disable iff (!rstN)
		!isBrz |=> (pc == $past(pc) + 16'd1))
		else begin
			assertFails++;
			$error("pc did not step by one after a non-BRZ instruction");
		end

	storeStrobe: assert property (@(posedge clk) disable iff (!rstN) dWe == isSt)
		else begin
			assertFails++;
			$error("dWe does not match the ST opcode");
		end

	// Absolute LD and ST use the field as address
	absAddress: assert property (@(posedge clk) disable iff (!rstN)
		(isLd || isSt) && !iw.addrForm.mode |-> dAddr == absAddr)
		else begin
			assertFails++;
			$error("dAddr differs from the absolute address field");
		end

endmodule

// File: verification/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

	localparam int resetCycles = 16;
	localparam int numTests = 6;
	localparam int progCycles = 34;   // Instructions executed over all programs
	localparam int cycleLimit = (progCycles + numTests * (resetCycles + 2)) * 3 / 2;
	localparam int driveDelay = 1;    // ns after the rising edge

	logic clk = 1'b0;
	logic rstN = 1'b0;
	logic [cpuPkg::wordW-1:0] instr;
	logic [cpuPkg::wordW-1:0] dRData;
	logic [cpuPkg::wordW-1:0] pc;
	logic [cpuPkg::wordW-1:0] dAddr;
	logic [cpuPkg::wordW-1:0] dWData;
	logic dWe;

	logic [15:0] imem [256];     // Indexed by pc[7:0]
	logic [15:0] dmem [65536];   // Full data address space
	int seed = 20065;

	// Shadow ISA state
	logic [15:0] sRegs [4];
	logic [15:0] sPc;
	logic sZf;
	int lowCycles = 0;

	string curTest = "startup";
	int testErrors = 0;
	int totalErrors = 0;
	int failedTests = 0;
	int testsRun = 0;
	int cycles = 0;
	int assertBase = 0;

	always #2 clk = ~clk;   // 4 ns period

	cpuCore dut0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.dRData(dRData),
		.pc(pc),
		.dAddr(dAddr),
		.dWData(dWData),
		.dWe(dWe)
	);

	bind cpuCore cpuCoreAsserts asserts0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.dAddr(dAddr),
		.dWe(dWe)
	);

	// Memories answer within the cycle
	assign instr = imem[pc[7:0]];
	assign dRData = dmem[dAddr];

	always @(posedge clk) begin
		if (dWe) begin
			dmem[dAddr] <= dWData;   // Store lands at the edge
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout: no end of test after %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	// Instruction encoders
	function automatic logic [15:0] addOp(input logic [1:0] rd, input logic [1:0] rs1,
		input logic [1:0] rs2);
		return {cpuPkg::opAdd, rd, rs1, rs2, 7'd0, 1'b0};
	endfunction

	function automatic logic [15:0] loadAbs(input logic [1:0] rd, input logic [10:0] addr);
		return {cpuPkg::opLd, rd, addr, 1'b0};
	endfunction

	function automatic logic [15:0] loadReg(input logic [1:0] rd, input logic [1:0] rs1);
		return {cpuPkg::opLd, rd, rs1, 2'd0, 7'd0, 1'b1};
	endfunction

	function automatic logic [15:0] storeAbs(input logic [1:0] rd, input logic [10:0] addr);
		return {cpuPkg::opSt, rd, addr, 1'b0};
	endfunction

	function automatic logic [15:0] storeReg(input logic [1:0] rs1, input logic [1:0] rs2);
		return {cpuPkg::opSt, 2'd0, rs1, rs2, 7'd0, 1'b1};
	endfunction

	function automatic logic [15:0] branchRel(input logic [10:0] off);
		return {cpuPkg::opBrz, 2'd0, off, 1'b0};
	endfunction

	function automatic logic [15:0] branchReg(input logic [1:0] rs1);
		return {cpuPkg::opBrz, 2'd0, rs1, 2'd0, 7'd0, 1'b1};
	endfunction

	task automatic reportMismatch(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		$display("** Error %s: %s expected %h actual %h", curTest, what, exp, act);
		testErrors++;
		totalErrors++;
	endtask

	// Shadow model steps one instruction per cycle and checks the DUT mid-cycle
	always @(negedge clk) begin
		cpuPkg::instrWord w;
		logic [15:0] addr;
		logic [15:0] sum;
		if (!rstN) begin
			lowCycles++;
			sPc = '0;
			sZf = 1'b0;
			for (int i = 0; i < 4; i++) begin
				sRegs[i] = '0;
			end
			assert (dWe === 1'b0) else reportMismatch("dWe in reset", 16'd0, {15'd0, dWe});
			if (lowCycles >= 2) begin   // First reset edge has passed
				assert (pc === 16'd0) else reportMismatch("pc in reset", 16'd0, pc);
			end
		end else begin
			lowCycles = 0;
			w = imem[sPc[7:0]];
			addr = w.addrForm.mode ? sRegs[w.regForm.rs1] : {5'd0, w.addrForm.addr};
			assert (pc === sPc) else reportMismatch("pc", sPc, pc);
			assert (dWe === (w.regForm.opcode == cpuPkg::opSt))
				else reportMismatch("dWe", {15'd0, w.regForm.opcode == cpuPkg::opSt},
					{15'd0, dWe});
			case (w.regForm.opcode)
				cpuPkg::opAdd: begin
					sum = sRegs[w.regForm.rs1] + sRegs[w.regForm.rs2];
					sZf = (sum == 16'd0);
					sRegs[w.regForm.rd] = sum;
					sPc = sPc + 16'd1;
				end
				cpuPkg::opLd: begin
					assert (dAddr === addr) else reportMismatch("load dAddr", addr, dAddr);
					sRegs[w.regForm.rd] = dmem[addr];
					sPc = sPc + 16'd1;
				end
				cpuPkg::opSt: begin
					// Absolute form stores rd, register form stores rs2
					sum = w.addrForm.mode ? sRegs[w.regForm.rs2] : sRegs[w.regForm.rd];
					assert (dAddr === addr) else reportMismatch("store dAddr", addr, dAddr);
					assert (dWData === sum) else reportMismatch("store dWData", sum, dWData);
					sPc = sPc + 16'd1;
				end
				default: begin
					if (!sZf) begin
						sPc = sPc + 16'd1;
					end else if (w.addrForm.mode) begin
						sPc = sRegs[w.regForm.rs1];
					end else begin
						sPc = sPc + {{5{w.addrForm.addr[10]}}, w.addrForm.addr};
					end
				end
			endcase
		end
	end

	// Enter reset and clear the program space
	task automatic beginTest(input string name);
		@(posedge clk);
		#driveDelay;
		rstN = 1'b0;
		curTest = name;
		testErrors = 0;
		assertBase = dut0.asserts0.assertFails;
		for (int i = 0; i < 256; i++) begin
			imem[i] = storeAbs(2'd0, 11'h7ff);   // Store filler, decoded as reset comes in
		end
	endtask

	// Release reset, run until pc reaches the end address, report
	task automatic finishTest(input logic [15:0] endAddr);
		int fails;
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;
		while (pc !== endAddr) begin
			@(negedge clk);
		end
		@(posedge clk);
		testsRun++;
		fails = testErrors + dut0.asserts0.assertFails - assertBase;
		if (fails == 0) begin
			$display("[%0d] %s: ok", testsRun, curTest);
		end else begin
			failedTests++;
			$display("[%0d] %s: %0d failed checks", testsRun, curTest, fails);
		end
	endtask

	initial begin
		for (int i = 0; i < 65536; i++) begin
			dmem[i] <= 16'($random(seed));
		end

		beginTest("reset");
		imem[0] = addOp(2'd1, 2'd0, 2'd0);
		imem[1] = storeAbs(2'd1, 11'h010);
		finishTest(16'd2);

		beginTest("add and store absolute");
		imem[0] = loadAbs(2'd1, 11'h020);
		imem[1] = loadAbs(2'd2, 11'h021);
		imem[2] = addOp(2'd3, 2'd1, 2'd2);
		imem[3] = storeAbs(2'd3, 11'h030);
		finishTest(16'd4);

		beginTest("load and store via register");
		imem[0] = loadAbs(2'd1, 11'h040);   // Random pointers
		imem[1] = loadAbs(2'd2, 11'h041);
		imem[2] = loadReg(2'd3, 2'd1);
		imem[3] = storeReg(2'd2, 2'd3);
		finishTest(16'd4);

		beginTest("branch relative");
		dmem[16'h060] <= 16'h0001;
		imem[0] = addOp(2'd1, 2'd0, 2'd0);   // Zero result
		imem[1] = branchRel(11'sd4);         // Taken forward to 5
		imem[2] = addOp(2'd3, 2'd2, 2'd0);   // Nonzero result
		imem[3] = branchRel(-11'sd3);        // Not taken
		imem[4] = storeAbs(2'd3, 11'h051);
		imem[5] = loadAbs(2'd2, 11'h060);
		imem[6] = branchRel(-11'sd4);        // Taken back once, then falls through
		finishTest(16'd7);

		beginTest("branch register");
		dmem[16'h070] <= 16'h0020;
		imem[0] = loadAbs(2'd1, 11'h070);
		imem[1] = addOp(2'd2, 2'd0, 2'd0);
		imem[2] = branchReg(2'd1);
		imem[3] = storeAbs(2'd1, 11'h071);   // Skipped
		imem[32] = storeAbs(2'd1, 11'h072);  // Landing point
		finishTest(16'h0021);

		beginTest("flag persistence");
		dmem[16'h080] <= 16'h0005;
		dmem[16'h081] <= 16'hfffb;
		imem[0] = loadAbs(2'd1, 11'h080);
		imem[1] = loadAbs(2'd2, 11'h081);
		imem[2] = addOp(2'd3, 2'd1, 2'd2);   // 5 plus -5
		imem[3] = loadAbs(2'd0, 11'h080);
		imem[4] = storeAbs(2'd3, 11'h082);
		imem[5] = branchRel(11'sd3);         // Follows the zero sum
		imem[6] = storeAbs(2'd0, 11'h083);
		imem[8] = addOp(2'd3, 2'd1, 2'd0);   // Nonzero sum clears flag
		imem[9] = storeAbs(2'd1, 11'h084);
		imem[10] = loadAbs(2'd2, 11'h081);
		imem[11] = branchRel(11'sd3);        // Not taken
		imem[12] = storeAbs(2'd3, 11'h085);
		finishTest(16'd13);

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
			testsRun, testsRun - failedTests, failedTests, dut0.asserts0.assertFails);
		if (failedTests == 0 && totalErrors == 0 && dut0.asserts0.assertFails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: build.f
src/cpuPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/pcUnit.sv
src/execUnit.sv
src/cpuCore.sv
verification/cpuCoreAsserts.sv
verification/cpuCoreTb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - src/cpuPkg.sv
  - src/instrDecoder.sv
  - src/regFile.sv
  - src/pcUnit.sv
  - src/execUnit.sv
  - src/cpuCore.sv
  - target: test
    files:
      - verification/cpuCoreAsserts.sv
      - verification/cpuCoreTb.sv
